// ==== src.f ====
+incdir+logic
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/phaseSequencer.sv
logic/ctrlWordEncoder.sv
logic/mipsCtrlUnit.sv
dv/ctrlUnitChecker.sv
dv/ctrlUnitTb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := ctrlUnitTb
FILELIST := src.f
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJDIR   := obj_dir
SIMBIN   := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/ctrlUnitTb.sv ====
`timescale 1ns/1ps

`include "ctrl_defs.svh"

module ctrlUnitTb import ctrlPkg::*; ();

    localparam int NUM_INSTR      = 300;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 10 + RESET_CYCLES + 100;

    logic     clk = 1'b0;
    logic     reset;
    opcode_t  opcode = '0;
    funct_t   funct = '0;
    logic     pcWrite;
    logic     irWrite;
    logic     regWrite;
    logic     aWrite;
    logic     bWrite;
    logic     aluOutWrite;
    logic     shiftSrc;
    sel2_t    regDst;
    sel2_t    aluSrcA;
    sel3_t    aluSrcB;
    sel3_t    memToReg;
    aluOp_t   aluOp;
    shiftOp_t shiftCtrl;
    logic     done;
    int       failCount;
    int       cycleCount = 0;
    int       issuedCount = 0;
    integer   seed = 1188;

    always #2 clk = ~clk;

    mipsCtrlUnit DUT (.*);

    ctrlUnitChecker #(.NUM_INSTR(NUM_INSTR)) uChecker (.*);

    // One in four draws is raw and the rest are legal encodings
    task automatic drawInstr(output opcode_t op, output funct_t fn);
        integer raw;
        integer pick;
        raw = $random(seed);
        op  = raw[5:0];
        fn  = raw[11:6];
        if ($unsigned($random(seed)) % 4 != 0) begin
            pick = $unsigned($random(seed)) % 7;
            op   = (pick == 6) ? `OPC_ADDI : `OPC_RTYPE;
            case (pick)
                0: fn = `FN_ADD;
                1: fn = `FN_SUB;
                2: fn = `FN_AND;
                3: fn = `FN_SLL;
                4: fn = `FN_SRL;
                5: fn = `FN_SRA;
                default: begin
                    // ADDI keeps a random funct field as part of its immediate
                end
            endcase
        end
    endtask

    // New instruction once the IR side sees pcWrite
    always @(posedge clk) begin : stimulus
        opcode_t nextOp;
        funct_t  nextFn;
        cycleCount <= cycleCount + 1;
        if (!reset && pcWrite) begin
            drawInstr(nextOp, nextFn);
            opcode      <= nextOp;
            funct       <= nextFn;
            issuedCount <= issuedCount + 1;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // Sampled away from the rising edge where the checker updates
        while (!done && cycleCount < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        if (done) begin
            if (failCount == 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
        end else begin
            $display("ERROR: timeout after %0d cycles, %0d of %0d instructions were issued",
                     cycleCount, issuedCount, NUM_INSTR);
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/ctrlUnitChecker.sv ====
`timescale 1ns/1ps

`include "ctrl_defs.svh"

module ctrlUnitChecker import ctrlPkg::*; #(
    parameter int NUM_INSTR = 300
) (
    input  logic     clk,
    input  logic     reset,
    input  opcode_t  opcode,
    input  funct_t   funct,
    input  logic     pcWrite,
    input  logic     irWrite,
    input  logic     regWrite,
    input  logic     aWrite,
    input  logic     bWrite,
    input  logic     aluOutWrite,
    input  logic     shiftSrc,
    input  sel2_t    regDst,
    input  sel2_t    aluSrcA,
    input  sel3_t    aluSrcB,
    input  sel3_t    memToReg,
    input  aluOp_t   aluOp,
    input  shiftOp_t shiftCtrl,
    output logic     done,
    output int       failCount
);

    typedef struct packed {
        logic     pcWrite;
        logic     irWrite;
        logic     regWrite;
        logic     aWrite;
        logic     bWrite;
        logic     aluOutWrite;
        logic     shiftSrc;
        sel2_t    regDst;
        sel2_t    aluSrcA;
        sel3_t    aluSrcB;
        sel3_t    memToReg;
        aluOp_t   aluOp;
        shiftOp_t shiftCtrl;
    } ctrlWord_t;

    ctrlWord_t  expWord = '0;
    phase_t     mPhase = FETCH;
    instrKind_t mExecKind = KIND_NONE;
    instrKind_t testKind = KIND_NONE;
    opcode_t    testOpcode = '0;
    funct_t     testFunct = '0;
    logic       started = 1'b0;
    logic       runDone = 1'b0;
    logic       regWriteSeen = 1'b0;
    int         relCycle = 0;
    int         testStart = 0;
    int         testIndex = 0;
    int         testErrors = 0;
    int         passTests = 0;
    int         failTests = 0;

    assign done      = runDone;
    assign failCount = failTests;

    function automatic instrKind_t decodeKind(opcode_t op, funct_t fn);
        if (op == `OPC_ADDI) begin
            return KIND_ADDI;
        end
        if (op != `OPC_RTYPE) begin
            return KIND_NONE;
        end
        case (fn)
            `FN_ADD: return KIND_ADD;
            `FN_SUB: return KIND_SUB;
            `FN_AND: return KIND_AND;
            `FN_SLL: return KIND_SLL;
            `FN_SRL: return KIND_SRL;
            `FN_SRA: return KIND_SRA;
            default: return KIND_NONE;
        endcase
    endfunction

    function automatic phase_t nextPhase(phase_t ph, instrKind_t k);
        case (ph)
            FETCH:       return WAIT;
            WAIT:        return WAIT2;
            WAIT2:       return DECODE;
            DECODE:      return DECODE_WAIT;
            DECODE_WAIT: begin
                case (k)
                    KIND_ADD, KIND_SUB, KIND_AND: return ALU_OP;
                    KIND_ADDI:                    return IMM_OP;
                    KIND_SLL, KIND_SRL, KIND_SRA: return SHIFT_LOAD;
                    default:                      return DELAY;
                endcase
            end
            ALU_OP:      return END_ALU;
            IMM_OP:      return END_IMM;
            SHIFT_LOAD:  return SHIFT_OP;
            SHIFT_OP:    return SHIFT_WAIT;
            SHIFT_WAIT:  return END_SHIFT;
            DELAY:       return FETCH;
            // The three END phases
            default:     return DELAY;
        endcase
    endfunction

    function automatic ctrlWord_t wordFor(phase_t ph, instrKind_t k);
        ctrlWord_t w;
        aluOp_t    aluCode;
        shiftOp_t  shiftCode;
        aluCode   = (k == KIND_SUB) ? 3'd2 : ((k == KIND_AND) ? 3'd3 : 3'd1);
        shiftCode = (k == KIND_SRL) ? 3'd3 : ((k == KIND_SRA) ? 3'd4 : 3'd2);
        // Flags are pcWrite irWrite regWrite aWrite bWrite aluOutWrite shiftSrc
        // Then regDst aluSrcA aluSrcB memToReg aluOp shiftCtrl
        case (ph)
            FETCH:       w = {7'b0000000, 2'd0, 2'd0, 3'd1, 3'd0, 3'd1, 3'd0};
            WAIT:        w = {7'b1000000, 2'd0, 2'd0, 3'd1, 3'd0, 3'd1, 3'd0};
            WAIT2:       w = {7'b0100000, 2'd0, 2'd0, 3'd1, 3'd3, 3'd0, 3'd0};
            DECODE:      w = {7'b0001110, 2'd0, 2'd0, 3'd4, 3'd3, 3'd1, 3'd0};
            DECODE_WAIT: w = {7'b0000000, 2'd0, 2'd0, 3'd0, 3'd3, 3'd1, 3'd0};
            ALU_OP:      w = {7'b0000010, 2'd0, 2'd1, 3'd0, 3'd0, aluCode, 3'd0};
            END_ALU:     w = {7'b0010000, 2'd3, 2'd0, 3'd0, 3'd0, 3'd0, 3'd0};
            IMM_OP:      w = {7'b0000010, 2'd0, 2'd1, 3'd3, 3'd0, 3'd1, 3'd0};
            END_IMM:     w = {7'b0010000, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd0};
            SHIFT_LOAD:  w = {7'b0000001, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, 3'd1};
            SHIFT_OP:    w = {7'b0000001, 2'd0, 2'd0, 3'd0, 3'd0, 3'd0, shiftCode};
            END_SHIFT:   w = {7'b0010000, 2'd3, 2'd0, 3'd0, 3'd2, 3'd0, 3'd0};
            default:     w = '0;
        endcase
        return w;
    endfunction

    // Distance between pcWrite pulses
    function automatic int cyclesFor(instrKind_t k);
        case (k)
            KIND_SLL, KIND_SRL, KIND_SRA: return 10;
            KIND_NONE:                    return 6;
            default:                      return 8;
        endcase
    endfunction

    task automatic checkField(input string name, input logic [2:0] actual,
                              input logic [2:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h (test %0d, cycle %0d)",
                     name, expected, actual, testIndex, relCycle);
            testErrors++;
        end
    endtask

    task automatic compareWord();
        checkField("pcWrite", {2'b00, pcWrite}, {2'b00, expWord.pcWrite});
        checkField("irWrite", {2'b00, irWrite}, {2'b00, expWord.irWrite});
        checkField("regWrite", {2'b00, regWrite}, {2'b00, expWord.regWrite});
        checkField("aWrite", {2'b00, aWrite}, {2'b00, expWord.aWrite});
        checkField("bWrite", {2'b00, bWrite}, {2'b00, expWord.bWrite});
        checkField("aluOutWrite", {2'b00, aluOutWrite}, {2'b00, expWord.aluOutWrite});
        checkField("shiftSrc", {2'b00, shiftSrc}, {2'b00, expWord.shiftSrc});
        checkField("regDst", {1'b0, regDst}, {1'b0, expWord.regDst});
        checkField("aluSrcA", {1'b0, aluSrcA}, {1'b0, expWord.aluSrcA});
        checkField("aluSrcB", aluSrcB, expWord.aluSrcB);
        checkField("memToReg", memToReg, expWord.memToReg);
        checkField("aluOp", aluOp, expWord.aluOp);
        checkField("shiftCtrl", shiftCtrl, expWord.shiftCtrl);
        if (pcWrite === 1'b1 && irWrite === 1'b1) begin
            $display("ERROR: pcWrite and irWrite are high together in test %0d", testIndex);
            testErrors++;
        end
    endtask

    // A test ends at the pcWrite that starts the next instruction
    task automatic closeTest();
        int    len;
        string verdict;
        len = relCycle - testStart;
        if (testIndex == 0) begin
            if (relCycle != 3) begin
                $display("ERROR: first pcWrite came in cycle %0d after reset, not 3", relCycle);
                testErrors++;
            end
        end else begin
            if (len != cyclesFor(testKind)) begin
                $display("ERROR: %s took %0d cycles from pcWrite to pcWrite instead of %0d",
                         testKind.name(), len, cyclesFor(testKind));
                testErrors++;
            end
            if (testKind == KIND_NONE && regWriteSeen) begin
                $display("ERROR: regWrite was raised for an unrecognised instruction");
                testErrors++;
            end
        end
        verdict = (testErrors == 0) ? "pass" : "fail";
        if (testErrors == 0) begin
            passTests++;
        end else begin
            failTests++;
        end
        if (testIndex == 0) begin
            $display("test 0 reset: first pcWrite in cycle %0d, %s", relCycle, verdict);
        end else begin
            $display("test %0d %s: opcode 0x%02h funct 0x%02h, %0d cycles, %s", testIndex,
                     testKind.name(), testOpcode, testFunct, len, verdict);
        end
        testIndex++;
        testStart    = relCycle;
        testErrors   = 0;
        regWriteSeen = 1'b0;
        if (testIndex > NUM_INSTR) begin
            $display("tests: %0d passed, %0d failed", passTests, failTests);
            runDone = 1'b1;
        end
    endtask

    // Outputs seen at an edge are the word registered at the previous edge
    always @(posedge clk) begin
        if (started) begin
            compareWord();
        end
        if (reset) begin
            started   = 1'b1;
            expWord   = '0;
            mPhase    = FETCH;
            mExecKind = KIND_NONE;
            relCycle  = 0;
        end else if (started) begin
            relCycle++;
            if (regWrite === 1'b1) begin
                regWriteSeen = 1'b1;
            end
            if (pcWrite === 1'b1) begin
                closeTest();
            end
            expWord = wordFor(mPhase, mExecKind);
            if (mPhase == DECODE_WAIT) begin
                mExecKind  = decodeKind(opcode, funct);
                testKind   = mExecKind;
                testOpcode = opcode;
                testFunct  = funct;
            end
            mPhase = nextPhase(mPhase, mExecKind);
        end
    end

endmodule

// ==== logic/mipsCtrlUnit.sv ====
`timescale 1ns/1ps

module mipsCtrlUnit import ctrlPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  opcode_t  opcode,
    input  funct_t   funct,
    output logic     pcWrite,
    output logic     irWrite,
    output logic     regWrite,
    output logic     aWrite,
    output logic     bWrite,
    output logic     aluOutWrite,
    output logic     shiftSrc,
    output sel2_t    regDst,
    output sel2_t    aluSrcA,
    output sel3_t    aluSrcB,
    output sel3_t    memToReg,
    output aluOp_t   aluOp,
    output shiftOp_t shiftCtrl
);

    instrKind_t kind;
    instrKind_t execKind;
    phase_t     phase;

    instrDecoder uDecoder (
        .opcode (opcode),
        .funct  (funct),
        .kind   (kind)
    );

    phaseSequencer uSequencer (
        .clk      (clk),
        .reset    (reset),
        .kind     (kind),
        .phase    (phase),
        .execKind (execKind)
    );

    ctrlWordEncoder uEncoder (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .execKind    (execKind),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .aluOutWrite (aluOutWrite),
        .shiftSrc    (shiftSrc),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .memToReg    (memToReg),
        .aluOp       (aluOp),
        .shiftCtrl   (shiftCtrl)
    );

endmodule

// ==== logic/ctrlWordEncoder.sv ====
`timescale 1ns/1ps

module ctrlWordEncoder import ctrlPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  phase_t     phase,
    input  instrKind_t execKind,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       aWrite,
    output logic       bWrite,
    output logic       aluOutWrite,
    output logic       shiftSrc,
    output sel2_t      regDst,
    output sel2_t      aluSrcA,
    output sel3_t      aluSrcB,
    output sel3_t      memToReg,
    output aluOp_t     aluOp,
    output shiftOp_t   shiftCtrl
);

    logic     pcWriteNxt;
    logic     irWriteNxt;
    logic     regWriteNxt;
    logic     aWriteNxt;
    logic     bWriteNxt;
    logic     aluOutWriteNxt;
    logic     shiftSrcNxt;
    sel2_t    regDstNxt;
    sel2_t    aluSrcANxt;
    sel3_t    aluSrcBNxt;
    sel3_t    memToRegNxt;
    aluOp_t   aluOpNxt;
    shiftOp_t shiftCtrlNxt;

    always_comb begin
        pcWriteNxt     = 1'b0;
        irWriteNxt     = 1'b0;
        regWriteNxt    = 1'b0;
        aWriteNxt      = 1'b0;
        bWriteNxt      = 1'b0;
        aluOutWriteNxt = 1'b0;
        shiftSrcNxt    = 1'b0;
        regDstNxt      = 2'd0;
        aluSrcANxt     = 2'd0;
        aluSrcBNxt     = 3'd0;
        memToRegNxt    = 3'd0;
        aluOpNxt       = 3'd0;
        shiftCtrlNxt   = 3'd0;
        case (phase)
            FETCH: begin
                // PC + 4 on the ALU
                aluSrcBNxt = 3'd1;
                aluOpNxt   = 3'd1;
            end
            WAIT: begin
                pcWriteNxt = 1'b1;
                aluSrcBNxt = 3'd1;
                aluOpNxt   = 3'd1;
            end
            WAIT2: begin
                irWriteNxt  = 1'b1;
                aluSrcBNxt  = 3'd1;
                memToRegNxt = 3'd3;
            end
            DECODE: begin
                // Branch target computed early into ALUOut
                aWriteNxt      = 1'b1;
                bWriteNxt      = 1'b1;
                aluOutWriteNxt = 1'b1;
                aluSrcBNxt     = 3'd4;
                aluOpNxt       = 3'd1;
                memToRegNxt    = 3'd3;
            end
            DECODE_WAIT: begin
                aluOpNxt    = 3'd1;
                memToRegNxt = 3'd3;
            end
            ALU_OP: begin
                aluOutWriteNxt = 1'b1;
                aluSrcANxt     = 2'd1;
                case (execKind)
                    KIND_SUB: aluOpNxt = 3'd2;
                    KIND_AND: aluOpNxt = 3'd3;
                    default:  aluOpNxt = 3'd1;
                endcase
            end
            END_ALU: begin
                regWriteNxt = 1'b1;
                regDstNxt   = 2'd3;
            end
            IMM_OP: begin
                aluOutWriteNxt = 1'b1;
                aluSrcANxt     = 2'd1;
                aluSrcBNxt     = 3'd3;
                aluOpNxt       = 3'd1;
            end
            END_IMM: begin
                // rt is the destination
                regWriteNxt = 1'b1;
            end
            SHIFT_LOAD: begin
                shiftSrcNxt  = 1'b1;
                shiftCtrlNxt = 3'd1;
            end
            SHIFT_OP: begin
                shiftSrcNxt = 1'b1;
                case (execKind)
                    KIND_SRL: shiftCtrlNxt = 3'd3;
                    KIND_SRA: shiftCtrlNxt = 3'd4;
                    default:  shiftCtrlNxt = 3'd2;
                endcase
            end
            END_SHIFT: begin
                regWriteNxt = 1'b1;
                regDstNxt   = 2'd3;
                memToRegNxt = 3'd2;
            end
            default: begin
                // SHIFT_WAIT and DELAY keep the word at zero
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            aWrite      <= 1'b0;
            bWrite      <= 1'b0;
            aluOutWrite <= 1'b0;
            shiftSrc    <= 1'b0;
            regDst      <= 2'd0;
            aluSrcA     <= 2'd0;
            aluSrcB     <= 3'd0;
            memToReg    <= 3'd0;
            aluOp       <= 3'd0;
            shiftCtrl   <= 3'd0;
        end else begin
            pcWrite     <= pcWriteNxt;
            irWrite     <= irWriteNxt;
            regWrite    <= regWriteNxt;
            aWrite      <= aWriteNxt;
            bWrite      <= bWriteNxt;
            aluOutWrite <= aluOutWriteNxt;
            shiftSrc    <= shiftSrcNxt;
            regDst      <= regDstNxt;
            aluSrcA     <= aluSrcANxt;
            aluSrcB     <= aluSrcBNxt;
            memToReg    <= memToRegNxt;
            aluOp       <= aluOpNxt;
            shiftCtrl   <= shiftCtrlNxt;
        end
    end

    // Fetch must not overwrite the PC while the IR is loading
    assert property (@(posedge clk) disable iff (reset) !(pcWrite && irWrite));

    assert property (@(posedge clk) disable iff (reset) !(regWrite && aWrite));

endmodule

// ==== logic/phaseSequencer.sv ====
`timescale 1ns/1ps

module phaseSequencer import ctrlPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instrKind_t kind,
    output phase_t     phase,
    output instrKind_t execKind
);

    phase_t phaseNext;

    always_comb begin
        phaseNext = phase;
        case (phase)
            FETCH: begin
                phaseNext = WAIT;
            end
            WAIT: begin
                phaseNext = WAIT2;
            end
            WAIT2: begin
                phaseNext = DECODE;
            end
            DECODE: begin
                phaseNext = DECODE_WAIT;
            end
            DECODE_WAIT: begin
                // Branch on the decoded kind once A and B hold the operands
                case (kind)
                    KIND_ADD, KIND_SUB, KIND_AND: begin
                        phaseNext = ALU_OP;
                    end
                    KIND_ADDI: begin
                        phaseNext = IMM_OP;
                    end
                    KIND_SLL, KIND_SRL, KIND_SRA: begin
                        phaseNext = SHIFT_LOAD;
                    end
                    default: begin
                        phaseNext = DELAY;
                    end
                endcase
            end
            ALU_OP: begin
                phaseNext = END_ALU;
            end
            END_ALU: begin
                phaseNext = DELAY;
            end
            IMM_OP: begin
                phaseNext = END_IMM;
            end
            END_IMM: begin
                phaseNext = DELAY;
            end
            SHIFT_LOAD: begin
                phaseNext = SHIFT_OP;
            end
            SHIFT_OP: begin
                phaseNext = SHIFT_WAIT;
            end
            SHIFT_WAIT: begin
                phaseNext = END_SHIFT;
            end
            END_SHIFT: begin
                phaseNext = DELAY;
            end
            default: begin
                phaseNext = FETCH;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= FETCH;
            execKind <= KIND_NONE;
        end else begin
            phase <= phaseNext;
            // Kind is captured once so later phases ignore funct
            if (phase == DECODE_WAIT) begin
                execKind <= kind;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        phase inside {FETCH, WAIT, WAIT2, DECODE, DECODE_WAIT, ALU_OP, END_ALU,
                      IMM_OP, END_IMM, SHIFT_LOAD, SHIFT_OP, SHIFT_WAIT,
                      END_SHIFT, DELAY});

    // Decode never stalls and never lands in the middle of a path
    assert property (@(posedge clk) disable iff (reset)
        phase == DECODE_WAIT |=> phase inside {ALU_OP, IMM_OP, SHIFT_LOAD, DELAY});

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/1ps

`include "ctrl_defs.svh"

module instrDecoder import ctrlPkg::*; (
    input  opcode_t    opcode,
    input  funct_t     funct,
    output instrKind_t kind
);

    always_comb begin
        kind = KIND_NONE;
        case (opcode)
            `OPC_RTYPE: begin
                // R-type is told apart by funct alone
                case (funct)
                    `FN_ADD: begin
                        kind = KIND_ADD;
                    end
                    `FN_SUB: begin
                        kind = KIND_SUB;
                    end
                    `FN_AND: begin
                        kind = KIND_AND;
                    end
                    `FN_SLL: begin
                        kind = KIND_SLL;
                    end
                    `FN_SRL: begin
                        kind = KIND_SRL;
                    end
                    `FN_SRA: begin
                        kind = KIND_SRA;
                    end
                    default: begin
                        kind = KIND_NONE;
                    end
                endcase
            end
            `OPC_ADDI: begin
                kind = KIND_ADDI;
            end
            default: begin
                // Unknown opcodes skip to the delay step
                kind = KIND_NONE;
            end
        endcase
    end

endmodule

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // Datapath mux selects
    typedef logic [1:0] sel2_t;
    typedef logic [2:0] sel3_t;

    // ALU and shifter commands
    typedef logic [2:0] aluOp_t;
    typedef logic [2:0] shiftOp_t;

    // Decoded instruction class
    typedef enum logic [2:0] {
        KIND_ADD,
        KIND_SUB,
        KIND_AND,
        KIND_SLL,
        KIND_SRL,
        KIND_SRA,
        KIND_ADDI,
        KIND_NONE
    } instrKind_t;

    // One phase per cycle of the multicycle datapath
    typedef enum logic [3:0] {
        FETCH,
        WAIT,
        WAIT2,
        DECODE,
        DECODE_WAIT,
        ALU_OP,
        END_ALU,
        IMM_OP,
        END_IMM,
        SHIFT_LOAD,
        SHIFT_OP,
        SHIFT_WAIT,
        END_SHIFT,
        DELAY
    } phase_t;

endpackage

// ==== logic/ctrl_defs.svh ====
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W  6

// Opcodes
`define OPC_RTYPE 6'h00
`define OPC_ADDI  6'h08

// R-type funct codes
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24

// Shamt shifts
`define FN_SLL 6'h00
`define FN_SRL 6'h02
`define FN_SRA 6'h03

`endif
